//--- vlog.f
+incdir+include
hw/loader_pkg.sv
hw/uart_rx.sv
hw/instr_assembler.sv
hw/instr_mem.sv
hw/boot_loader_top.sv
sim/tb_boot_loader.sv

//--- run.sh
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_boot_loader -f vlog.f -Mdir obj_dir -o tb_boot_loader

./obj_dir/tb_boot_loader 2>&1 | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

//--- sim/tb_boot_loader.sv
`timescale 1ns/1ns
`default_nettype none

`include "loader_consts.svh"

module tb_boot_loader;

    // 34 bytes at 160 cycles each, plus reset and fetches, with wide margin.
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int SETTLE_LIMIT   = 64;

    logic                   clk;
    logic                   rst;
    logic                   rx;
    logic                   load_start;
    logic                   load_stop;
    loader_pkg::imem_addr_t fetch_addr;
    loader_pkg::word_t      fetch_data;
    logic                   loading;
    loader_pkg::imem_addr_t load_addr;

    loader_pkg::word_t shadow [`LD_IMEM_DEPTH]; // Expected memory image.
    int                exp_addr;
    int                pass_count;
    int                fail_count;
    int                cycle_count;
    integer            seed;

    boot_loader_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .load_start (load_start),
        .load_stop  (load_stop),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .loading    (loading),
        .load_addr  (load_addr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~

    // First byte received lands in bits 7 to 0.
    function automatic loader_pkg::word_t pack_word(input loader_pkg::byte_t b0,
                                                    input loader_pkg::byte_t b1,
                                                    input loader_pkg::byte_t b2,
                                                    input loader_pkg::byte_t b3);
        return {b3, b2, b1, b0};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        bit ok;
        ok = (actual === expected);
        assert (ok) else begin
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
            fail_count++;
        end
        if (ok)
            pass_count++;
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("Test %s: %s", name, (fail_count == errs_before) ? "pass" : "fail");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // UART driver
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic drive_bit(input logic value);
        int n;
        @(posedge clk);
        rx <= value;
        for (n = 1; n < `LD_CLKS_PER_BIT; n++)
            @(posedge clk);
    endtask

    // 8N1 frame, LSB first.
    task automatic send_byte(input loader_pkg::byte_t data);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++)
            drive_bit(data[i]);
        drive_bit(1'b1);
    endtask

    task automatic send_bytes(input int count, input bit in_window);
        loader_pkg::byte_t lanes [`LD_BYTES_PER_WORD];
        int i;
        for (i = 0; i < count; i++) begin
            lanes[i % `LD_BYTES_PER_WORD] = 8'($random(seed));
            send_byte(lanes[i % `LD_BYTES_PER_WORD]);
            if (in_window && (i % `LD_BYTES_PER_WORD == `LD_BYTES_PER_WORD - 1)) begin
                shadow[exp_addr] = pack_word(lanes[0], lanes[1], lanes[2], lanes[3]);
                exp_addr++;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Control and fetch
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic pulse_start();
        @(posedge clk);
        load_start <= 1'b1;
        @(posedge clk);
        load_start <= 1'b0;
        exp_addr = 0; // Start clears the address.
    endtask

    task automatic pulse_stop();
        @(posedge clk);
        load_stop <= 1'b1;
        @(posedge clk);
        load_stop <= 1'b0;
    endtask

    // Polls until the address settles, bounded.
    task automatic wait_addr(input int expected);
        int n;
        n = 0;
        @(negedge clk);
        while (load_addr != 8'(expected) && n < SETTLE_LIMIT) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic fetch_check(input int addr);
        @(posedge clk);
        fetch_addr <= 8'(addr);
        @(posedge clk); // Registered read.
        @(negedge clk);
        check_value("fetch_data", shadow[addr], fetch_data);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        int errs;
        int a;
        rst        = 1'b1;
        rx         = 1'b1;
        load_start = 1'b0;
        load_stop  = 1'b0;
        fetch_addr = '0;
        seed       = 58;
        exp_addr   = 0;
        pass_count = 0;
        fail_count = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        errs = fail_count;
        pulse_start();
        send_bytes(16, 1'b1);
        wait_addr(4);
        check_value("load_addr", 32'(exp_addr), 32'(load_addr));
        pulse_stop();
        @(negedge clk);
        check_value("loading", 32'd0, 32'(loading));
        for (a = 0; a < 4; a++)
            fetch_check(a);
        report_test("1 basic load", errs);

        errs = fail_count;
        send_bytes(4, 1'b0); // Window closed.
        wait_addr(4);
        check_value("load_addr", 32'd4, 32'(load_addr));
        for (a = 0; a < 4; a++)
            fetch_check(a);
        report_test("2 idle bytes ignored", errs);

        errs = fail_count;
        pulse_start();
        send_bytes(6, 1'b1);
        wait_addr(1);
        check_value("load_addr", 32'd1, 32'(load_addr));
        pulse_stop();
        fetch_check(0);
        fetch_check(1); // Still from test 1.
        report_test("3 partial word discarded", errs);

        errs = fail_count;
        pulse_start();
        send_bytes(8, 1'b1);
        wait_addr(2);
        check_value("load_addr", 32'd2, 32'(load_addr));
        pulse_stop();
        fetch_check(0);
        fetch_check(1);
        report_test("4 restart from zero", errs);

        errs = fail_count;
        @(posedge clk);
        load_start <= 1'b1;
        @(negedge clk);
        check_value("loading", 32'd0, 32'(loading));
        @(posedge clk);
        load_start <= 1'b0;
        @(negedge clk);
        check_value("loading", 32'd1, 32'(loading));
        @(posedge clk);
        load_stop <= 1'b1;
        @(negedge clk);
        check_value("loading", 32'd1, 32'(loading));
        @(posedge clk);
        load_stop <= 1'b0;
        @(negedge clk);
        check_value("loading", 32'd0, 32'(loading));
        report_test("5 load state visible", errs);

        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/boot_loader_top.sv
`timescale 1ns/1ns
`default_nettype none

module boot_loader_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rx,
    input  logic                    load_start,
    input  logic                    load_stop,
    input  loader_pkg::imem_addr_t  fetch_addr,
    output loader_pkg::word_t       fetch_data,
    output logic                    loading,
    output loader_pkg::imem_addr_t  load_addr
);

    loader_pkg::byte_t      rx_byte;
    logic                   rx_valid;
    logic                   wr_en;
    loader_pkg::imem_addr_t wr_addr;
    loader_pkg::word_t      wr_data;

    // Serial bytes in.
    uart_rx u_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    instr_assembler u_instr_assembler (
        .clk        (clk),
        .rst        (rst),
        .load_start (load_start),
        .load_stop  (load_stop),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .loading    (loading),
        .load_addr  (load_addr),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    // Processor side reads through the fetch port.
    instr_mem u_instr_mem (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

endmodule

`default_nettype wire

//--- hw/instr_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "loader_consts.svh"

module instr_mem (
    input  logic                    clk,
    input  logic                    wr_en,
    input  loader_pkg::imem_addr_t  wr_addr,
    input  loader_pkg::word_t       wr_data,
    input  loader_pkg::imem_addr_t  fetch_addr,
    output loader_pkg::word_t       fetch_data
);

    // Block RAM style storage.
    loader_pkg::word_t mem [`LD_IMEM_DEPTH];

    // ~~~~~~~~~~~~~~~~~~~~
    // Write port
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Fetch port
    // ~~~~~~~~~~~~~~~~~~~~

    // Read before write on a shared address.
    always_ff @(posedge clk) begin
        fetch_data <= mem[fetch_addr];
    end

endmodule

`default_nettype wire

//--- hw/instr_assembler.sv
`timescale 1ns/1ns
`default_nettype none

`include "loader_consts.svh"

module instr_assembler (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_start,
    input  logic                    load_stop,
    input  loader_pkg::byte_t       rx_byte,
    input  logic                    rx_valid,
    output logic                    loading,
    output loader_pkg::imem_addr_t  load_addr,
    output logic                    wr_en,
    output loader_pkg::imem_addr_t  wr_addr,
    output loader_pkg::word_t       wr_data
);

    localparam loader_pkg::byte_idx_t LAST_LANE =
        loader_pkg::byte_idx_t'(`LD_BYTES_PER_WORD - 1);

    loader_pkg::byte_idx_t byte_idx;
    loader_pkg::word_t     word_buf;
    logic                  byte_take;
    logic                  word_done;

    // A byte landing with either control pulse belongs to no window.
    assign byte_take = loading && rx_valid && !load_start && !load_stop;
    assign word_done = byte_take && (byte_idx == LAST_LANE);

    // ~~~~~~~~~~~~~~~~~~~~
    // Load window
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            loading <= 1'b0;
        end else if (load_start) begin
            loading <= 1'b1; // Start wins over stop.
        end else if (load_stop) begin
            loading <= 1'b0;
        end
    end

    // Cleared on stop too, so a partial word is dropped.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_idx <= '0;
        end else if (load_start || load_stop) begin
            byte_idx <= '0;
        end else if (byte_take) begin
            byte_idx <= byte_idx + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Byte packing
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (byte_take)
            word_buf[byte_idx*8 +: 8] <= rx_byte;
    end

    // Last byte goes straight into the write word.
    always_ff @(posedge clk) begin
        if (word_done) begin
            wr_data <= {rx_byte, word_buf[`LD_WORD_W-9:0]};
            wr_addr <= load_addr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= word_done;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Address counter
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_addr <= '0;
        end else if (load_start) begin
            load_addr <= '0;
        end else if (wr_en) begin
            load_addr <= load_addr + 1'b1; // Wraps at memory depth.
        end
    end

    a_wr_in_window: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> loading);

    a_wr_single: assert property (@(posedge clk) disable iff (rst)
        wr_en |=> !wr_en);

endmodule

`default_nettype wire

//--- hw/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

`include "loader_consts.svh"

module uart_rx (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx,
    output loader_pkg::byte_t  rx_byte,
    output logic               rx_valid
);

    localparam int CNT_W = $clog2(`LD_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`LD_CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`LD_CLKS_PER_BIT - 1);

    logic                  rx_meta;
    logic                  rx_sync;
    loader_pkg::rx_state_t state;
    logic [CNT_W-1:0]      clk_cnt;
    logic [2:0]            bit_cnt;
    loader_pkg::byte_t     shift_reg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Input synchronizer
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta <= 1'b1; // Line idles high.
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Frame FSM
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= loader_pkg::rx_idle;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                loader_pkg::rx_idle: begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (!rx_sync) state <= loader_pkg::rx_start;
                end
                loader_pkg::rx_start: begin
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;
                        // A glitch that is gone by mid bit is not a start.
                        state <= rx_sync ? loader_pkg::rx_idle : loader_pkg::rx_data;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                loader_pkg::rx_data: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= loader_pkg::rx_stop;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                loader_pkg::rx_stop: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt  <= '0;
                        rx_valid <= rx_sync; // Framing error drops the byte.
                        state    <= loader_pkg::rx_idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= loader_pkg::rx_idle;
            endcase
        end
    end

    // Data bits arrive LSB first.
    always_ff @(posedge clk) begin
        if (state == loader_pkg::rx_data && clk_cnt == FULL_BIT)
            shift_reg <= {rx_sync, shift_reg[7:1]};
    end

    always_ff @(posedge clk) begin
        if (state == loader_pkg::rx_stop && clk_cnt == FULL_BIT && rx_sync)
            rx_byte <= shift_reg;
    end

    a_valid_single: assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

//--- hw/loader_pkg.sv
`default_nettype none

`include "loader_consts.svh"

package loader_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [`LD_WORD_W-1:0] word_t;
    typedef logic [`LD_ADDR_W-1:0] imem_addr_t;
    typedef logic [1:0] byte_idx_t; // Lane within a word.

    // Receiver FSM.
    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

endpackage

`default_nettype wire

//--- include/loader_consts.svh
`ifndef LOADER_CONSTS_SVH
`define LOADER_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// UART bit timing
// ~~~~~~~~~~~~~~~~~~~~

// Clock cycles per serial bit, kept small for short runs.
`define LD_CLKS_PER_BIT 16

// ~~~~~~~~~~~~~~~~~~~~
// Word and memory sizes
// ~~~~~~~~~~~~~~~~~~~~

`define LD_BYTES_PER_WORD 4
`define LD_WORD_W 32
`define LD_IMEM_DEPTH 256
`define LD_ADDR_W 8 // Must cover LD_IMEM_DEPTH.

`endif
